// ==== include/soc_macros.svh ====
// Size and address constants of the SoC wrapper, included by the package, the interface and RTL
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Host register bus, byte addressed
`define ADDR_WIDTH 8
`define DATA_WIDTH 32

`define GPIO_WIDTH 24

// Clock edges from reset synchronization to init_done
`define INIT_DELAY_CYCLES 16

// Peripheral windows
`define GPIO_BASE 8'h00
`define I2C_BASE 8'h40
`define WINDOW_BYTES 64
`define OFS_WIDTH 4       // Word offset bits inside a window

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Builds tb_board_top with Verilator, runs it into sim.log and fails if the log reports a failure
rm -f sim.log
{ verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_board_top &&
  ./obj_dir/Vtb_board_top; } > sim.log 2>&1 || echo "Verification failed" >> sim.log
grep -q "Verification failed" sim.log && { echo "Simulation failed, see sim.log"; exit 1; } ||
  { echo "Simulation passed"; exit 0; }

// ==== sim/soc_cases.txt ====
// op_addr_wdata_gpin_expected_err, one hex word per line, gp_in applies from that case on
// op 0 write, 1 read, 2 wait wdata cycles, 3 LFSR write, 4 SDA hold, 5 pin check, f end
3_00_00000000_000000_00000000_0
3_04_00000000_000000_00000000_0
0_00_ffa5c3f0_000000_00000000_0
5_00_00000000_000000_00a5c3f0_0
1_00_00000000_000000_00a5c3f0_0
0_10_00000011_000000_00000000_0
2_00_00000003_120011_00000000_0
1_08_00000000_120011_00120011_0
1_0c_00000000_120011_00120011_0
5_02_00000000_120011_00000001_0
0_0c_00000011_120011_00000000_0
1_0c_00000000_120011_00120000_0
5_02_00000000_120011_00000000_0
0_40_00000002_120011_00000000_0
5_03_00000000_120011_00000000_0
5_04_00000000_120011_00000001_0
2_00_00000003_120011_00000000_0
1_44_00000000_120011_00000002_0
0_40_00000003_120011_00000000_0
4_00_00000001_120011_00000000_0
2_00_00000003_120011_00000000_0
1_44_00000000_120011_00000001_0
1_14_00000000_120011_00000000_1
1_48_00000000_120011_00000000_1
0_14_ffffffff_120011_00000000_1
0_c0_ffffffff_120011_00000000_1
1_00_00000000_120011_00a5c3f0_0
f_00_00000000_120011_00000000_0

// ==== sim/tb_board_top.sv ====
// Testbench for board_top that plays the case file against the DUT and checks pins and read data
`include "soc_macros.svh"

module tb_board_top;

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned MAX_CASES    = 64;
  localparam int unsigned INIT_LIMIT   = 40;
  localparam int unsigned RVALID_LIMIT = 8;
  localparam logic [`ADDR_WIDTH-1:0] OE_ADDR   = `GPIO_BASE + 8'h04;
  localparam logic [`ADDR_WIDTH-1:0] HOLE_ADDR = 8'hc0;  // Outside both windows

  logic                   ext_clk_100_i = 1'b0;
  logic                   arst_n_i      = 1'b0;
  logic [`ADDR_WIDTH-1:0] host_addr_i   = '0;
  logic [`DATA_WIDTH-1:0] host_wdata_i  = '0;
  logic                   host_we_i     = 1'b0;
  logic                   host_re_i     = 1'b0;
  logic [`GPIO_WIDTH-1:0] gp_in_i       = '0;
  logic                   i2c_scl_i     = 1'b1;
  logic                   i2c_sda_i     = 1'b1;
  logic [`DATA_WIDTH-1:0] host_rdata_o;
  logic                   host_rvalid_o;
  logic                   host_err_o;
  logic                   init_done_led_o;
  logic [`GPIO_WIDTH-1:0] gp_out_o;
  logic [`GPIO_WIDTH-1:0] gp_oe_o;
  logic                   gpio_irq_o;
  logic                   i2c_scl_o;
  logic                   i2c_sda_o;

  logic [103:0] cases [MAX_CASES];  // op, addr, wdata, gp_in, expected, err
  int unsigned  case_count   = 0;
  logic         cases_loaded = 1'b0;
  logic [15:0]  lfsr_state   = 16'd93;
  logic         sda_pull     = 1'b0;  // Device model holds SDA low

  board_top i_dut (.*);

  always #(CLK_PERIOD / 2) ext_clk_100_i = ~ext_clk_100_i;

  // I2C device model where each line follows its DUT output unless SDA is held low
  always @(negedge ext_clk_100_i) begin
    i2c_scl_i <= i2c_scl_o;
    i2c_sda_i <= i2c_sda_o & ~sda_pull;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_data(input string name, input logic [`DATA_WIDTH-1:0] exp_v,
                            input logic [`DATA_WIDTH-1:0] act_v);
    if (act_v !== exp_v)
      fail_run($sformatf("Mismatch at %0t: %s expected %h, got %h", $time, name, exp_v, act_v));
  endtask

  task automatic check_pins(input string name, input logic [`GPIO_WIDTH-1:0] exp_v,
                            input logic [`GPIO_WIDTH-1:0] act_v);
    if (act_v !== exp_v)
      fail_run($sformatf("Mismatch at %0t: %s expected %h, got %h", $time, name, exp_v, act_v));
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v)
      fail_run($sformatf("Mismatch at %0t: %s expected %b, got %b", $time, name, exp_v, act_v));
  endtask

  // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
  endfunction

  task automatic draw_word(output logic [`DATA_WIDTH-1:0] word);
    for (int i = 0; i < `DATA_WIDTH; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      word[i]    = lfsr_state[0];
    end
  endtask

  // Starts and ends on a falling edge
  // The error flag shows after the edge that follows the write
  task automatic host_write(input logic [`ADDR_WIDTH-1:0] addr,
                            input logic [`DATA_WIDTH-1:0] data, input logic exp_err);
    host_addr_i  = addr;
    host_wdata_i = data;
    host_we_i    = 1'b1;
    @(negedge ext_clk_100_i);
    host_we_i = 1'b0;
    @(negedge ext_clk_100_i);
    check_bit("host_err_o", exp_err, host_err_o);
    check_bit("host_rvalid_o", 1'b0, host_rvalid_o);
  endtask

  task automatic host_read(input logic [`ADDR_WIDTH-1:0] addr,
                           output logic [`DATA_WIDTH-1:0] data, output logic err);
    int unsigned waits;
    host_addr_i = addr;
    host_re_i   = 1'b1;
    @(negedge ext_clk_100_i);
    host_re_i = 1'b0;
    waits     = 0;
    while (!host_rvalid_o) begin
      if (waits == RVALID_LIMIT)
        fail_run($sformatf("No read valid pulse for address %h", addr));
      @(negedge ext_clk_100_i);
      waits++;
    end
    if (waits != 1)
      fail_run($sformatf("Read valid for address %h came %0d edges after the strobe", addr,
                         waits + 1));
    data = host_rdata_o;
    err  = host_err_o;
    @(negedge ext_clk_100_i);
    check_bit("host_rvalid_o", 1'b0, host_rvalid_o);  // One cycle pulse
  endtask

  task automatic play_case(input logic [103:0] c);
    logic [3:0]             op;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] wdata;
    logic [`DATA_WIDTH-1:0] exp_data;
    logic                   exp_err;
    logic [`DATA_WIDTH-1:0] rdata;
    logic                   rerr;
    op       = c[103:100];
    addr     = c[99:92];
    wdata    = c[91:60];
    exp_data = c[35:4];
    exp_err  = c[0];
    gp_in_i  = c[59:36];
    case (op)
      4'h0: host_write(addr, wdata, exp_err);
      4'h1: begin
        host_read(addr, rdata, rerr);
        check_data("host_rdata_o", exp_data, rdata);
        check_bit("host_err_o", exp_err, rerr);
      end
      4'h2: repeat (wdata) @(negedge ext_clk_100_i);
      4'h3: begin
        draw_word(wdata);
        host_write(addr, wdata, 1'b0);
        if (addr == OE_ADDR) check_pins("gp_oe_o", wdata[`GPIO_WIDTH-1:0], gp_oe_o);
        else check_pins("gp_out_o", wdata[`GPIO_WIDTH-1:0], gp_out_o);
        host_read(addr, rdata, rerr);
        check_data("host_rdata_o", `DATA_WIDTH'(wdata[`GPIO_WIDTH-1:0]), rdata);  // Upper bits zero
      end
      4'h4: begin
        sda_pull = wdata[0];
        @(negedge ext_clk_100_i);
      end
      4'h5: begin
        case (addr)
          8'h00:   check_pins("gp_out_o", exp_data[`GPIO_WIDTH-1:0], gp_out_o);
          8'h01:   check_pins("gp_oe_o", exp_data[`GPIO_WIDTH-1:0], gp_oe_o);
          8'h02:   check_bit("gpio_irq_o", exp_data[0], gpio_irq_o);
          8'h03:   check_bit("i2c_scl_o", exp_data[0], i2c_scl_o);
          default: check_bit("i2c_sda_o", exp_data[0], i2c_sda_o);
        endcase
      end
      default: fail_run($sformatf("Unknown operation %h in the case file", op));
    endcase
  endtask

  // Counts edges from reset release to init_done while an early write and read must be ignored
  task automatic check_init_delay();
    int unsigned edges;
    edges        = 0;
    host_wdata_i = '1;
    while (!init_done_led_o && edges < INIT_LIMIT) begin
      host_addr_i = (edges == 8) ? HOLE_ADDR : `GPIO_BASE;
      host_we_i   = (edges == 4);
      host_re_i   = (edges == 8);
      @(negedge ext_clk_100_i);
      edges++;
      check_bit("host_err_o", 1'b0, host_err_o);
      check_bit("host_rvalid_o", 1'b0, host_rvalid_o);
    end
    host_we_i = 1'b0;
    host_re_i = 1'b0;
    if (edges != `INIT_DELAY_CYCLES + 2)
      fail_run($sformatf("init_done_led_o rose after %0d edges instead of %0d", edges,
                         `INIT_DELAY_CYCLES + 2));
    check_pins("gp_out_o", '0, gp_out_o);
  endtask

  initial begin
    $readmemh("sim/soc_cases.txt", cases);
    while (case_count < MAX_CASES && cases[case_count][103:100] !== 4'hf) case_count++;
    cases_loaded = 1'b1;
    repeat (2) @(negedge ext_clk_100_i);
    check_bit("init_done_led_o", 1'b0, init_done_led_o);
    check_pins("gp_out_o", '0, gp_out_o);
    check_pins("gp_oe_o", '0, gp_oe_o);
    check_bit("i2c_scl_o", 1'b1, i2c_scl_o);
    check_bit("i2c_sda_o", 1'b1, i2c_sda_o);
    arst_n_i = 1'b1;
    check_init_delay();
    for (int i = 0; i < case_count; i++) play_case(cases[i]);
    $display("Verification passed");
    $finish;
  end

  // Watchdog whose limit grows with the number of cases
  initial begin
    wait (cases_loaded);
    #((case_count * 10 + 100) * CLK_PERIOD);
    fail_run($sformatf("Timeout, the cases did not finish within %0d clock periods",
                       case_count * 10 + 100));
  end

endmodule

// ==== sources.f ====
+incdir+include
verilog/soc_pkg.sv
verilog/reg_bus_if.sv
verilog/reset_ctrl.sv
verilog/reg_bus_decoder.sv
verilog/gpio_ctrl.sv
verilog/i2c_line_ctrl.sv
verilog/board_top.sv
sim/tb_board_top.sv

// ==== verilog/board_top.sv ====
// Board-level wrapper for the simulation build, split pin directions and a host register bus
`include "soc_macros.svh"

module board_top (
  input  logic                   ext_clk_100_i,
  input  logic                   arst_n_i,

  // Host register bus, stands in for the processor
  input  logic [`ADDR_WIDTH-1:0] host_addr_i,
  input  logic [`DATA_WIDTH-1:0] host_wdata_i,
  input  logic                   host_we_i,
  input  logic                   host_re_i,
  output logic [`DATA_WIDTH-1:0] host_rdata_o,
  output logic                   host_rvalid_o,
  output logic                   host_err_o,

  output logic                   init_done_led_o,

  // GPIO pins
  input  logic [`GPIO_WIDTH-1:0] gp_in_i,
  output logic [`GPIO_WIDTH-1:0] gp_out_o,
  output logic [`GPIO_WIDTH-1:0] gp_oe_o,
  output logic                   gpio_irq_o,

  // I2C lines, no pads in this build
  input  logic                   i2c_scl_i,
  input  logic                   i2c_sda_i,
  output logic                   i2c_scl_o,
  output logic                   i2c_sda_o
);

  logic sys_rst_n;
  logic init_done;

  reg_bus_if gpio_bus ();
  reg_bus_if i2c_bus ();

  assign init_done_led_o = init_done;

  reset_ctrl reset_ctrl_inst (
    .ext_clk_100_i(ext_clk_100_i),
    .arst_n_i     (arst_n_i),
    .sys_rst_n_o  (sys_rst_n),
    .init_done_o  (init_done)
  );

  reg_bus_decoder reg_bus_decoder_inst (
    .ext_clk_100_i(ext_clk_100_i),
    .sys_rst_n_i  (sys_rst_n),
    .init_done_i  (init_done),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_we_i    (host_we_i),
    .host_re_i    (host_re_i),
    .host_rdata_o (host_rdata_o),
    .host_rvalid_o(host_rvalid_o),
    .host_err_o   (host_err_o),
    .gpio_bus     (gpio_bus.decoder),
    .i2c_bus      (i2c_bus.decoder)
  );

  gpio_ctrl gpio_ctrl_inst (
    .ext_clk_100_i(ext_clk_100_i),
    .sys_rst_n_i  (sys_rst_n),
    .bus          (gpio_bus.peripheral),
    .gp_in_i      (gp_in_i),
    .gp_out_o     (gp_out_o),
    .gp_oe_o      (gp_oe_o),
    .gpio_irq_o   (gpio_irq_o)
  );

  i2c_line_ctrl i2c_line_ctrl_inst (
    .ext_clk_100_i(ext_clk_100_i),
    .sys_rst_n_i  (sys_rst_n),
    .bus          (i2c_bus.peripheral),
    .i2c_scl_i    (i2c_scl_i),
    .i2c_sda_i    (i2c_sda_i),
    .i2c_scl_o    (i2c_scl_o),
    .i2c_sda_o    (i2c_sda_o)
  );

endmodule

// ==== verilog/gpio_ctrl.sv ====
// GPIO port with output enables, synchronized inputs, sticky edge capture and an interrupt
`include "soc_macros.svh"

module gpio_ctrl (
  input  logic                   ext_clk_100_i,
  input  logic                   sys_rst_n_i,
  reg_bus_if.peripheral          bus,
  input  logic [`GPIO_WIDTH-1:0] gp_in_i,
  output logic [`GPIO_WIDTH-1:0] gp_out_o,
  output logic [`GPIO_WIDTH-1:0] gp_oe_o,
  output logic                   gpio_irq_o
);

  localparam int unsigned PAD_W = `DATA_WIDTH - `GPIO_WIDTH;

  logic [`GPIO_WIDTH-1:0] in_meta;
  logic [`GPIO_WIDTH-1:0] in_sync;
  logic [`GPIO_WIDTH-1:0] in_prev;   // Previous synchronized value, for edge detection
  logic [`GPIO_WIDTH-1:0] rise;
  logic [`GPIO_WIDTH-1:0] edge_sts_q;
  logic [`GPIO_WIDTH-1:0] edge_clr;
  logic [`GPIO_WIDTH-1:0] irq_en_q;
  logic [`GPIO_WIDTH-1:0] rd_word;
  logic                   wr;

  assign wr   = bus.sel & bus.we;
  assign rise = in_sync & ~in_prev;

  // Write-one-to-clear mask for the edge status
  assign edge_clr = (wr && (bus.ofs == soc_pkg::OFS_EDGE)) ? bus.wdata[`GPIO_WIDTH-1:0] : '0;

  always_ff @(posedge ext_clk_100_i or negedge sys_rst_n_i) begin
    if (!sys_rst_n_i) begin
      in_meta    <= '0;
      in_sync    <= '0;
      in_prev    <= '0;
      edge_sts_q <= '0;
      gp_out_o   <= soc_pkg::GPIO_OUT_RESET;
      gp_oe_o    <= soc_pkg::GPIO_OE_RESET;
      irq_en_q   <= soc_pkg::GPIO_IRQ_EN_RESET;
    end else begin
      in_meta    <= gp_in_i;
      in_sync    <= in_meta;
      in_prev    <= in_sync;
      edge_sts_q <= (edge_sts_q & ~edge_clr) | rise;  // New edge wins over a clear
      if (wr) begin
        case (bus.ofs)
          soc_pkg::OFS_OUT:    gp_out_o <= bus.wdata[`GPIO_WIDTH-1:0];
          soc_pkg::OFS_OE:     gp_oe_o  <= bus.wdata[`GPIO_WIDTH-1:0];
          soc_pkg::OFS_IRQ_EN: irq_en_q <= bus.wdata[`GPIO_WIDTH-1:0];
          default: ;  // IN is read only, EDGE handled above
        endcase
      end
    end
  end

  always_comb begin
    case (bus.ofs)
      soc_pkg::OFS_OUT:    rd_word = gp_out_o;
      soc_pkg::OFS_OE:     rd_word = gp_oe_o;
      soc_pkg::OFS_IN:     rd_word = in_sync;
      soc_pkg::OFS_EDGE:   rd_word = edge_sts_q;
      soc_pkg::OFS_IRQ_EN: rd_word = irq_en_q;
      default:             rd_word = '0;
    endcase
  end

  assign bus.rdata = (bus.sel && bus.re) ? {{PAD_W{1'b0}}, rd_word} : '0;

  assign gpio_irq_o = |(edge_sts_q & irq_en_q);

  // Pins must stay quiet for the whole reset, up to the synchronized release
  a_pins_idle_in_reset: assert property (
    @(posedge ext_clk_100_i)
    !sys_rst_n_i |-> (gp_out_o == '0) && (gp_oe_o == '0)
  );

endmodule

// ==== verilog/i2c_line_ctrl.sv ====
// Open-drain I2C line controller, software bit-bangs SCL and SDA through its drive register
`include "soc_macros.svh"

module i2c_line_ctrl (
  input  logic          ext_clk_100_i,
  input  logic          sys_rst_n_i,
  reg_bus_if.peripheral bus,
  input  logic          i2c_scl_i,
  input  logic          i2c_sda_i,
  output logic          i2c_scl_o,
  output logic          i2c_sda_o
);

  logic [1:0]             drive_q;    // 1 releases the line, 0 pulls it low
  logic [1:0]             line_meta;
  logic [1:0]             line_sync;
  logic [1:0]             lines;
  logic [`DATA_WIDTH-1:0] rd_word;
  logic                   wr;

  assign wr = bus.sel & bus.we & (bus.ofs == soc_pkg::OFS_I2C_CTRL);

  always_ff @(posedge ext_clk_100_i or negedge sys_rst_n_i) begin
    if (!sys_rst_n_i) begin
      drive_q   <= soc_pkg::I2C_CTRL_RESET;
      line_meta <= 2'b11;  // Idle bus is high
      line_sync <= 2'b11;
    end else begin
      line_meta[soc_pkg::I2C_SCL_BIT] <= i2c_scl_i;
      line_meta[soc_pkg::I2C_SDA_BIT] <= i2c_sda_i;
      line_sync                       <= line_meta;
      if (wr) begin
        drive_q <= bus.wdata[1:0];
      end
    end
  end

  // A line we pull low reads low whatever the pin shows
  assign lines = line_sync & drive_q;

  assign i2c_scl_o = drive_q[soc_pkg::I2C_SCL_BIT];
  assign i2c_sda_o = drive_q[soc_pkg::I2C_SDA_BIT];

  always_comb begin
    case (bus.ofs)
      soc_pkg::OFS_I2C_CTRL:  rd_word = {{(`DATA_WIDTH-2){1'b0}}, drive_q};
      soc_pkg::OFS_I2C_LINES: rd_word = {{(`DATA_WIDTH-2){1'b0}}, lines};
      default:                rd_word = '0;
    endcase
  end

  assign bus.rdata = (bus.sel && bus.re) ? rd_word : '0;

endmodule

// ==== verilog/reg_bus_decoder.sv ====
// Host bus address decoder, routes strobes to the GPIO and I2C windows and returns read data
`include "soc_macros.svh"

module reg_bus_decoder (
  input  logic                   ext_clk_100_i,
  input  logic                   sys_rst_n_i,
  input  logic                   init_done_i,
  input  logic [`ADDR_WIDTH-1:0] host_addr_i,
  input  logic [`DATA_WIDTH-1:0] host_wdata_i,
  input  logic                   host_we_i,
  input  logic                   host_re_i,
  output logic [`DATA_WIDTH-1:0] host_rdata_o,
  output logic                   host_rvalid_o,
  output logic                   host_err_o,
  reg_bus_if.decoder             gpio_bus,
  reg_bus_if.decoder             i2c_bus
);

  localparam int unsigned WIN_LSB = $clog2(`WINDOW_BYTES);
  localparam logic [`ADDR_WIDTH-1:0] GPIO_BASE = `GPIO_BASE;
  localparam logic [`ADDR_WIDTH-1:0] I2C_BASE  = `I2C_BASE;

  logic                           acc_we;
  logic                           acc_re;
  logic [`ADDR_WIDTH-WIN_LSB-1:0] win;
  soc_pkg::reg_offset_e           word_ofs;
  logic                           gpio_hit;
  logic                           i2c_hit;
  logic                           rd_pend;
  logic                           err_pend;
  logic [`DATA_WIDTH-1:0]         rdata_q;

  // Nothing gets through before initialization is done
  assign acc_we = host_we_i & init_done_i;
  assign acc_re = host_re_i & init_done_i;

  assign win      = host_addr_i[`ADDR_WIDTH-1:WIN_LSB];
  assign word_ofs = soc_pkg::reg_offset_e'(host_addr_i[WIN_LSB-1 -: `OFS_WIDTH]);  // Byte bits dropped

  assign gpio_hit = (win == GPIO_BASE[`ADDR_WIDTH-1:WIN_LSB]) &&
                    (word_ofs <= soc_pkg::GPIO_LAST_OFS);
  assign i2c_hit  = (win == I2C_BASE[`ADDR_WIDTH-1:WIN_LSB]) &&
                    (word_ofs <= soc_pkg::I2C_LAST_OFS);

  assign gpio_bus.sel   = gpio_hit;
  assign gpio_bus.we    = acc_we;
  assign gpio_bus.re    = acc_re;
  assign gpio_bus.ofs   = word_ofs;
  assign gpio_bus.wdata = host_wdata_i;

  assign i2c_bus.sel   = i2c_hit;
  assign i2c_bus.we    = acc_we;
  assign i2c_bus.re    = acc_re;
  assign i2c_bus.ofs   = word_ofs;
  assign i2c_bus.wdata = host_wdata_i;

  // Two-stage response, valid and error show after the edge following the strobe
  always_ff @(posedge ext_clk_100_i or negedge sys_rst_n_i) begin
    if (!sys_rst_n_i) begin
      rd_pend       <= 1'b0;
      err_pend      <= 1'b0;
      host_rvalid_o <= 1'b0;
      host_err_o    <= 1'b0;
    end else begin
      rd_pend       <= acc_re;
      err_pend      <= (acc_re | acc_we) & ~(gpio_hit | i2c_hit);
      host_rvalid_o <= rd_pend;
      host_err_o    <= err_pend;
    end
  end

  // Unselected peripherals return zero, so an OR is enough
  always_ff @(posedge ext_clk_100_i) begin
    rdata_q      <= gpio_bus.rdata | i2c_bus.rdata;
    host_rdata_o <= rdata_q;
  end

  a_rvalid_after_read: assert property (
    @(posedge ext_clk_100_i) disable iff (!sys_rst_n_i)
    host_rvalid_o |-> $past(acc_re, 2)
  );

  // Host contract
  a_one_strobe: assert property (
    @(posedge ext_clk_100_i) disable iff (!sys_rst_n_i)
    !(host_we_i && host_re_i)
  );

endmodule

// ==== verilog/reg_bus_if.sv ====
// Register port between the address decoder and one peripheral, one instance per peripheral in the top
`include "soc_macros.svh"

interface reg_bus_if;

  logic                   sel;    // Peripheral addressed at a mapped offset
  logic                   we;
  logic                   re;
  soc_pkg::reg_offset_e   ofs;    // Word offset inside the window
  logic [`DATA_WIDTH-1:0] wdata;
  logic [`DATA_WIDTH-1:0] rdata;  // Zero unless selected and read

  modport decoder (
    output sel,
    output we,
    output re,
    output ofs,
    output wdata,
    input  rdata
  );

  modport peripheral (
    input  sel,
    input  we,
    input  re,
    input  ofs,
    input  wdata,
    output rdata
  );

endinterface

// ==== verilog/reset_ctrl.sv ====
// Reset synchronizer and initialization delay, instantiated once in the top to reset all blocks
`include "soc_macros.svh"

module reset_ctrl (
  input  logic ext_clk_100_i,
  input  logic arst_n_i,
  output logic sys_rst_n_o,
  output logic init_done_o
);

  localparam int unsigned CNT_W = $clog2(`INIT_DELAY_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`INIT_DELAY_CYCLES - 1);

  logic             rst_meta;
  logic [CNT_W-1:0] delay_cnt;

  // Asserts at once, releases on the second edge
  always_ff @(posedge ext_clk_100_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_meta    <= 1'b0;
      sys_rst_n_o <= 1'b0;
    end else begin
      rst_meta    <= 1'b1;
      sys_rst_n_o <= rst_meta;
    end
  end

  // Counter runs only once the system reset is released
  always_ff @(posedge ext_clk_100_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      delay_cnt   <= CNT_LOAD;
      init_done_o <= 1'b0;
    end else if (sys_rst_n_o) begin
      if (delay_cnt != '0) begin
        delay_cnt <= delay_cnt - 1'b1;
      end else begin
        init_done_o <= 1'b1;  // Sticks until the next reset
      end
    end
  end

  // Once the system is out of reset, init_done can only go away with a new reset
  a_init_done_sticky: assert property (
    @(posedge ext_clk_100_i) disable iff (!sys_rst_n_o)
    !$fell(init_done_o)
  );

endmodule

// ==== verilog/soc_pkg.sv ====
// Register map types and reset values shared by the decoder and the peripherals, used as soc_pkg::name
`include "soc_macros.svh"

package soc_pkg;

  // Word offsets inside a peripheral window
  typedef enum logic [`OFS_WIDTH-1:0] {
    OFS_OUT    = 4'd0,
    OFS_OE     = 4'd1,
    OFS_IN     = 4'd2,
    OFS_EDGE   = 4'd3,  // Sticky rising-edge status, write 1 to clear
    OFS_IRQ_EN = 4'd4
  } reg_offset_e;

  // The I2C window reuses the two lowest offsets
  localparam reg_offset_e OFS_I2C_CTRL  = OFS_OUT;
  localparam reg_offset_e OFS_I2C_LINES = OFS_OE;

  // Highest implemented offset per window, anything above is unmapped
  localparam reg_offset_e GPIO_LAST_OFS = OFS_IRQ_EN;
  localparam reg_offset_e I2C_LAST_OFS  = OFS_I2C_LINES;

  // GPIO register reset values
  localparam logic [`GPIO_WIDTH-1:0] GPIO_OUT_RESET    = '0;
  localparam logic [`GPIO_WIDTH-1:0] GPIO_OE_RESET     = '0;  // All pins as inputs
  localparam logic [`GPIO_WIDTH-1:0] GPIO_IRQ_EN_RESET = '0;

  localparam logic [1:0] I2C_CTRL_RESET = 2'b11;  // Both lines released

  // Bit positions in the I2C drive and line registers
  localparam int unsigned I2C_SCL_BIT = 0;
  localparam int unsigned I2C_SDA_BIT = 1;

endpackage
